// File: design/ddr_crc5.sv
// running CRC-5 (x^5+x^2+1) over the data bytes of a frame, seeded on the first byte
`timescale 1ns/1ns
`include "ddr_rx_settings.svh"

module ddr_crc5 (
  input  logic                     i_sys_clk,
  input  logic                     i_sys_rst,
  input  ddr_rx_pkg::ddr_rx_byte_t i_byte,
  output logic [4:0]               o_crc_value
);

  logic [4:0] crc_q;
  logic [4:0] crc_base;

  // eight serial steps unrolled, msb first
  function automatic logic [4:0] fold_byte(input logic [4:0] crc_in, input logic [7:0] data);
    logic [4:0] c;
    logic       fb;
    c = crc_in;
    for (int i = 7; i >= 0; i--)
    begin
      fb = c[4] ^ data[i];
      c  = {c[3:0], 1'b0} ^ (fb ? 5'b00101 : 5'b00000);
    end
    return c;
  endfunction

  // restart from the seed on the frame's first byte
  assign crc_base = i_byte.first ? `DDR_CRC_SEED : crc_q;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
      crc_q <= `DDR_CRC_SEED;
    else if (i_byte.valid)
      crc_q <= fold_byte(crc_base, i_byte.data);
  end

  assign o_crc_value = crc_q;

endmodule

// File: design/ddr_rx_deser.sv
// SDA deserializer, shifts in each field per receive mode and checks parity, preamble, token and CRC
`timescale 1ns/1ns

module ddr_rx_deser (
  input  logic                     i_sys_clk,
  input  logic                     i_sys_rst,
  input  logic                     i_scl_pos_edge,
  input  logic                     i_scl_neg_edge,
  input  logic                     i_sda,
  input  logic                     i_last_word,
  input  ddr_rx_pkg::rx_mode_e     i_rx_mode,
  input  logic [4:0]               i_crc_value,
  output ddr_rx_pkg::ddr_rx_step_t o_step,
  output ddr_rx_pkg::ddr_rx_byte_t o_byte,
  output logic                     o_pre
);

  localparam logic [1:0] CRC_PRE_EXP = 2'b01;
  localparam logic [3:0] TOKEN_EXP   = 4'b1100;

  logic [2:0]           bit_cnt_q;
  logic [7:0]           shift_q;
  logic [7:0]           field_val;
  logic [15:0]          word_q;
  logic [1:0]           par_calc;
  logic                 bit_strobe;
  logic                 field_end;
  logic                 field_err;
  logic                 first_pend_q;
  logic                 pre_q;
  logic                 step_done_q;
  logic                 step_err_q;
  logic                 step_last_q;
  ddr_rx_pkg::rx_mode_e step_mode_q;
  logic [7:0]           byte_data_q;
  logic                 byte_valid_q;
  logic                 byte_first_q;

  // index of the last bit in each field
  function automatic logic [2:0] field_last(input ddr_rx_pkg::rx_mode_e mode);
    case (mode)
      ddr_rx_pkg::DESERIALIZING_BYTE: field_last = 3'd7;
      ddr_rx_pkg::CHECK_TOKEN:        field_last = 3'd3;
      ddr_rx_pkg::CHECK_CRC_VALUE:    field_last = 3'd4;
      default:                        field_last = 3'd1;
    endcase
  endfunction

  // one bit per SCL edge, either direction
  assign bit_strobe = (i_scl_pos_edge || i_scl_neg_edge) && (i_rx_mode != ddr_rx_pkg::IDLE);
  assign field_end  = bit_strobe && (bit_cnt_q == field_last(i_rx_mode));
  // msb first, current SDA is the newest bit
  assign field_val  = {shift_q[6:0], i_sda};

  // parity 1 over odd bits, parity 0 over even bits inverted
  assign par_calc = {^(word_q & 16'hAAAA), ~^(word_q & 16'h5555)};

  always_comb
  begin
    case (i_rx_mode)
      ddr_rx_pkg::CRC_PREAMBLE:    field_err = (field_val[1:0] != CRC_PRE_EXP);
      ddr_rx_pkg::CHECK_TOKEN:     field_err = (field_val[3:0] != TOKEN_EXP);
      ddr_rx_pkg::CHECK_PAR_VALUE: field_err = (field_val[1:0] != par_calc);
      ddr_rx_pkg::CHECK_CRC_VALUE: field_err = (field_val[4:0] != i_crc_value);
      default:                     field_err = 1'b0;
    endcase
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      bit_cnt_q    <= '0;
      first_pend_q <= 1'b1;
      pre_q        <= 1'b0;
      step_done_q  <= 1'b0;
      step_err_q   <= 1'b0;
      step_last_q  <= 1'b0;
      step_mode_q  <= ddr_rx_pkg::IDLE;
      byte_valid_q <= 1'b0;
      byte_first_q <= 1'b0;
    end
    else
    begin
      step_done_q  <= 1'b0;
      byte_valid_q <= 1'b0;
      byte_first_q <= 1'b0;
      // arm the frame-first marker between frames
      if (i_rx_mode == ddr_rx_pkg::IDLE)
        first_pend_q <= 1'b1;
      if (field_end)
      begin
        bit_cnt_q   <= '0;
        step_done_q <= 1'b1;
        step_mode_q <= i_rx_mode;
        step_err_q  <= field_err;
        step_last_q <= i_last_word && (i_rx_mode == ddr_rx_pkg::CHECK_PAR_VALUE);
        // second preamble bit, reported only
        if (i_rx_mode == ddr_rx_pkg::PREAMBLE)
          pre_q <= i_sda;
        if (i_rx_mode == ddr_rx_pkg::DESERIALIZING_BYTE)
        begin
          byte_valid_q <= 1'b1;
          byte_first_q <= first_pend_q;
          first_pend_q <= 1'b0;
        end
      end
      else if (bit_strobe)
        bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  // shift and byte data
  always_ff @(posedge i_sys_clk)
  begin
    if (bit_strobe)
      shift_q <= field_val;
    if (field_end && (i_rx_mode == ddr_rx_pkg::DESERIALIZING_BYTE))
    begin
      byte_data_q <= field_val;
      // high byte arrives first
      word_q      <= {word_q[7:0], field_val};
    end
  end

  assign o_step = '{done: step_done_q, mode: step_mode_q, error: step_err_q, last: step_last_q};
  assign o_byte = '{data: byte_data_q, valid: byte_valid_q, first: byte_first_q};
  assign o_pre  = pre_q;

endmodule

// File: design/ddr_rx_mode_seq.sv
// frame sequencer, walks the receive modes of one HDR-DDR read frame on field completions
`timescale 1ns/1ns
`include "ddr_rx_settings.svh"

module ddr_rx_mode_seq (
  input  logic                     i_sys_clk,
  input  logic                     i_sys_rst,
  input  logic                     i_rx_start,
  input  ddr_rx_pkg::ddr_rx_cmd_t  i_rx_cmd,
  input  ddr_rx_pkg::ddr_rx_step_t i_step,
  output ddr_rx_pkg::rx_mode_e     o_rx_mode,
  output logic                     o_busy,
  output logic                     o_last_word
);

  ddr_rx_pkg::rx_mode_e  mode_q;
  ddr_rx_pkg::word_cnt_t words_q;
  ddr_rx_pkg::word_cnt_t word_idx_q;
  ddr_rx_pkg::word_cnt_t word_next;
  logic                  byte_q;
  logic                  busy_q;

  assign word_next = word_idx_q + ddr_rx_pkg::word_cnt_t'(1);

  // final word of the request, clamped at the frame maximum
  assign o_last_word = (word_next == words_q)
                    || (word_next == ddr_rx_pkg::word_cnt_t'(`DDR_MAX_WORDS));

  assign o_rx_mode = mode_q;
  assign o_busy    = busy_q;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      mode_q     <= ddr_rx_pkg::IDLE;
      words_q    <= '0;
      word_idx_q <= '0;
      byte_q     <= 1'b0;
      busy_q     <= 1'b0;
    end
    else if (!busy_q)
    begin
      // new request only taken while idle
      if (i_rx_start)
      begin
        busy_q     <= 1'b1;
        mode_q     <= ddr_rx_pkg::PREAMBLE;
        words_q    <= i_rx_cmd.words;
        word_idx_q <= '0;
        byte_q     <= 1'b0;
      end
    end
    else if (i_step.done)
    begin
      case (mode_q)
        ddr_rx_pkg::PREAMBLE:
        begin
          byte_q <= 1'b0;
          mode_q <= ddr_rx_pkg::DESERIALIZING_BYTE;
        end
        ddr_rx_pkg::DESERIALIZING_BYTE:
        begin
          // two bytes per word, then parity
          byte_q <= ~byte_q;
          if (byte_q)
            mode_q <= ddr_rx_pkg::CHECK_PAR_VALUE;
        end
        ddr_rx_pkg::CHECK_PAR_VALUE:
        begin
          word_idx_q <= word_next;
          // last flag comes back from the deserializer with the step
          if (i_step.last)
            mode_q <= ddr_rx_pkg::CRC_PREAMBLE;
          else
            mode_q <= ddr_rx_pkg::PREAMBLE;
        end
        ddr_rx_pkg::CRC_PREAMBLE:
          mode_q <= ddr_rx_pkg::CHECK_TOKEN;
        ddr_rx_pkg::CHECK_TOKEN:
          mode_q <= ddr_rx_pkg::CHECK_CRC_VALUE;
        default:
        begin
          // crc field closes the frame
          mode_q <= ddr_rx_pkg::IDLE;
          busy_q <= 1'b0;
        end
      endcase
    end
  end

endmodule

// File: design/ddr_rx_pkg.sv
// receive-mode encoding and shared packed record types for the HDR-DDR receive path
`include "ddr_rx_settings.svh"

package ddr_rx_pkg;

  // wide enough to hold a word count of 0 to DDR_MAX_WORDS
  localparam int WORD_CNT_W = $clog2(`DDR_MAX_WORDS + 1);

  typedef logic [WORD_CNT_W-1:0] word_cnt_t;

  // receive modes, same codes as the existing controller
  // IDLE reuses the old error-recovery code, which is not supported here
  typedef enum logic [2:0] {
    PREAMBLE           = 3'b000,
    CRC_PREAMBLE       = 3'b001,
    DESERIALIZING_BYTE = 3'b011,
    CHECK_TOKEN        = 3'b111,
    CHECK_PAR_VALUE    = 3'b110,
    CHECK_CRC_VALUE    = 3'b010,
    IDLE               = 3'b100
  } rx_mode_e;

  // frame request, words is 1 to DDR_MAX_WORDS
  typedef struct packed {
    word_cnt_t words;
  } ddr_rx_cmd_t;

  // field completion from the deserializer
  typedef struct packed {
    logic     done;
    rx_mode_e mode;
    logic     error;
    logic     last;
  } ddr_rx_step_t;

  // completed data byte toward CRC and result collector
  typedef struct packed {
    logic [7:0] data;
    logic       valid;
    logic       first;
  } ddr_rx_byte_t;

  typedef struct packed {
    logic [15:0] data;
    logic        parity_err;
  } ddr_rx_word_t;

  // end-of-frame status
  typedef struct packed {
    logic      pre_err;
    logic      token_err;
    logic      crc_err;
    word_cnt_t words;
  } ddr_rx_status_t;

endpackage

// File: design/ddr_rx_result.sv
// result collector, forms word results on parity steps and the frame status on the CRC step
`timescale 1ns/1ns

module ddr_rx_result (
  input  logic                       i_sys_clk,
  input  logic                       i_sys_rst,
  input  ddr_rx_pkg::ddr_rx_step_t   i_step,
  input  ddr_rx_pkg::ddr_rx_byte_t   i_byte,
  output logic                       o_word_valid,
  output ddr_rx_pkg::ddr_rx_word_t   o_word,
  output logic                       o_status_valid,
  output ddr_rx_pkg::ddr_rx_status_t o_status
);

  logic [15:0]           word_q;
  logic [15:0]           word_out_q;
  logic                  par_err_q;
  logic                  word_valid_q;
  logic                  status_valid_q;
  logic                  pre_err_q;
  logic                  token_err_q;
  logic                  crc_err_q;
  ddr_rx_pkg::word_cnt_t word_cnt_q;
  logic                  par_step;

  assign par_step = i_step.done && (i_step.mode == ddr_rx_pkg::CHECK_PAR_VALUE);

  // word assembly, high byte first
  always_ff @(posedge i_sys_clk)
  begin
    if (i_byte.valid)
      word_q <= {word_q[7:0], i_byte.data};
    if (par_step)
      word_out_q <= word_q;
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      word_valid_q   <= 1'b0;
      status_valid_q <= 1'b0;
      par_err_q      <= 1'b0;
      pre_err_q      <= 1'b0;
      token_err_q    <= 1'b0;
      crc_err_q      <= 1'b0;
      word_cnt_q     <= '0;
    end
    else
    begin
      word_valid_q   <= par_step;
      status_valid_q <= i_step.done && (i_step.mode == ddr_rx_pkg::CHECK_CRC_VALUE);
      // new frame, drop last frame's status
      if (i_byte.valid && i_byte.first)
      begin
        pre_err_q   <= 1'b0;
        token_err_q <= 1'b0;
        crc_err_q   <= 1'b0;
        word_cnt_q  <= '0;
      end
      if (par_step)
      begin
        par_err_q  <= i_step.error;
        word_cnt_q <= word_cnt_q + ddr_rx_pkg::word_cnt_t'(1);
      end
      // crc word checks, latched for the status
      if (i_step.done && (i_step.mode == ddr_rx_pkg::CRC_PREAMBLE))
        pre_err_q <= i_step.error;
      if (i_step.done && (i_step.mode == ddr_rx_pkg::CHECK_TOKEN))
        token_err_q <= i_step.error;
      if (i_step.done && (i_step.mode == ddr_rx_pkg::CHECK_CRC_VALUE))
        crc_err_q <= i_step.error;
    end
  end

  assign o_word_valid   = word_valid_q;
  assign o_word         = '{data: word_out_q, parity_err: par_err_q};
  assign o_status_valid = status_valid_q;
  assign o_status       = '{pre_err: pre_err_q, token_err: token_err_q,
                            crc_err: crc_err_q, words: word_cnt_q};

endmodule

// File: design/ddr_rx_settings.svh
// timing and sizing constants for the HDR-DDR receive path, included by RTL and testbench
`ifndef DDR_RX_SETTINGS_SVH
`define DDR_RX_SETTINGS_SVH

// system clocks per SCL half period
// SDA is sampled once per half period, so each bit costs this many clocks
`define DDR_SCL_HALF 4

// largest number of data words in one frame
// also sets the width of the word counters in the package
`define DDR_MAX_WORDS 4

// CRC-5 start value, all ones
// reloaded on the first data byte of every frame
`define DDR_CRC_SEED 5'b11111

`endif

// File: design/ddr_rx_top.sv
// HDR-DDR receive path top, wires SCL generator, sequencer, deserializer, CRC and collector
`timescale 1ns/1ns

module ddr_rx_top (
  input  logic                       i_sys_clk,
  input  logic                       i_sys_rst,
  input  logic                       i_rx_start,
  input  ddr_rx_pkg::ddr_rx_cmd_t    i_rx_cmd,
  input  logic                       i_sda,
  output logic                       o_scl,
  output logic                       o_pre,
  output logic                       o_busy,
  output logic                       o_word_valid,
  output ddr_rx_pkg::ddr_rx_word_t   o_word,
  output logic                       o_status_valid,
  output ddr_rx_pkg::ddr_rx_status_t o_status
);

  logic                     scl_pos_edge;
  logic                     scl_neg_edge;
  logic                     last_word;
  logic [4:0]               crc_value;
  ddr_rx_pkg::rx_mode_e     rx_mode;
  ddr_rx_pkg::ddr_rx_step_t step;
  ddr_rx_pkg::ddr_rx_byte_t rx_byte;

  // SCL runs for as long as a frame is in flight
  ddr_scl_gen u_scl_gen (
    .i_sys_clk      (i_sys_clk),
    .i_sys_rst      (i_sys_rst),
    .i_run          (o_busy),
    .o_scl          (o_scl),
    .o_scl_pos_edge (scl_pos_edge),
    .o_scl_neg_edge (scl_neg_edge)
  );

  ddr_rx_mode_seq u_mode_seq (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst   (i_sys_rst),
    .i_rx_start  (i_rx_start),
    .i_rx_cmd    (i_rx_cmd),
    .i_step      (step),
    .o_rx_mode   (rx_mode),
    .o_busy      (o_busy),
    .o_last_word (last_word)
  );

  ddr_rx_deser u_deser (
    .i_sys_clk      (i_sys_clk),
    .i_sys_rst      (i_sys_rst),
    .i_scl_pos_edge (scl_pos_edge),
    .i_scl_neg_edge (scl_neg_edge),
    .i_sda          (i_sda),
    .i_last_word    (last_word),
    .i_rx_mode      (rx_mode),
    .i_crc_value    (crc_value),
    .o_step         (step),
    .o_byte         (rx_byte),
    .o_pre          (o_pre)
  );

  ddr_crc5 u_crc5 (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst   (i_sys_rst),
    .i_byte      (rx_byte),
    .o_crc_value (crc_value)
  );

  ddr_rx_result u_result (
    .i_sys_clk      (i_sys_clk),
    .i_sys_rst      (i_sys_rst),
    .i_step         (step),
    .i_byte         (rx_byte),
    .o_word_valid   (o_word_valid),
    .o_word         (o_word),
    .o_status_valid (o_status_valid),
    .o_status       (o_status)
  );

endmodule

// File: design/ddr_scl_gen.sv
// SCL generator, toggles SCL every half period while a frame runs and flags each edge
`timescale 1ns/1ns
`include "ddr_rx_settings.svh"

module ddr_scl_gen (
  input  logic i_sys_clk,
  input  logic i_sys_rst,
  input  logic i_run,
  output logic o_scl,
  output logic o_scl_pos_edge,
  output logic o_scl_neg_edge
);

  localparam int HALF  = `DDR_SCL_HALF;
  localparam int CNT_W = (HALF > 1) ? $clog2(HALF) : 1;

  logic [CNT_W-1:0] half_cnt_q;
  logic             scl_q;
  logic             toggle;

  // last clock of the half period
  // the deserializer samples SDA on this same clock
  assign toggle = i_run && (half_cnt_q == CNT_W'(HALF - 1));

  assign o_scl_pos_edge = toggle && !scl_q;
  assign o_scl_neg_edge = toggle && scl_q;
  assign o_scl          = scl_q;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      half_cnt_q <= '0;
      scl_q      <= 1'b1;
    end
    else if (!i_run)
    begin
      // bus idle, park SCL high and restart the half period
      half_cnt_q <= '0;
      scl_q      <= 1'b1;
    end
    else if (toggle)
    begin
      half_cnt_q <= '0;
      scl_q      <= ~scl_q;
    end
    else
      half_cnt_q <= half_cnt_q + 1'b1;
  end

endmodule

// File: files.f
+incdir+design
design/ddr_rx_pkg.sv
design/ddr_scl_gen.sv
design/ddr_rx_mode_seq.sv
design/ddr_rx_deser.sv
design/ddr_crc5.sv
design/ddr_rx_result.sv
design/ddr_rx_top.sv
test/ddr_rx_tb.sv

// File: test/ddr_rx_tb.sv
// directed testbench that plays the SDA target of the HDR-DDR receive path and checks its results
`timescale 1ns/1ns
`include "ddr_rx_settings.svh"

module ddr_rx_tb;

  localparam int CLK_NS   = 100;
  localparam int HALF     = `DDR_SCL_HALF;
  localparam int MAX_BITS = 20 * `DDR_MAX_WORDS + 11;
  // frames of 1, 4, 4 words, then four frames of 2 words
  localparam int TOTAL_BITS = 31 + 91 + 91 + 4 * 51;
  localparam int FRAMES     = 7;
  localparam int WATCHDOG_NS = (TOTAL_BITS * 2 * HALF + FRAMES * 40 + 20) * CLK_NS;

  logic                       i_sys_clk;
  logic                       i_sys_rst;
  logic                       i_rx_start;
  ddr_rx_pkg::ddr_rx_cmd_t    i_rx_cmd;
  logic                       i_sda;
  logic                       o_scl;
  logic                       o_pre;
  logic                       o_busy;
  logic                       o_word_valid;
  ddr_rx_pkg::ddr_rx_word_t   o_word;
  logic                       o_status_valid;
  ddr_rx_pkg::ddr_rx_status_t o_status;

  integer                     seed = 37863;
  logic [15:0]                tx_data [0:`DDR_MAX_WORDS-1];
  ddr_rx_pkg::ddr_rx_word_t   got_words [$];
  ddr_rx_pkg::ddr_rx_status_t got_status;
  logic                       status_seen;
  logic                       busy_at_status;
  logic                       busy_before_status;
  logic                       busy_prev;

  ddr_rx_top dut0 (
    .i_sys_clk      (i_sys_clk),
    .i_sys_rst      (i_sys_rst),
    .i_rx_start     (i_rx_start),
    .i_rx_cmd       (i_rx_cmd),
    .i_sda          (i_sda),
    .o_scl          (o_scl),
    .o_pre          (o_pre),
    .o_busy         (o_busy),
    .o_word_valid   (o_word_valid),
    .o_word         (o_word),
    .o_status_valid (o_status_valid),
    .o_status       (o_status)
  );

  initial
  begin
    i_sys_clk = 1'b0;
    forever #(CLK_NS / 2) i_sys_clk = ~i_sys_clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "stopping after first error");
  endtask

  // whole run bounded by the total bit count of all frames
  initial
  begin
    #(WATCHDOG_NS);
    fail_run("watchdog expired, the DUT stopped making progress");
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp));
  endtask

  task automatic check_word(input string name, input ddr_rx_pkg::ddr_rx_word_t got,
                            input ddr_rx_pkg::ddr_rx_word_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED t=%0t %s got %h/%b expected %h/%b", $time, name,
                         got.data, got.parity_err, exp.data, exp.parity_err));
  endtask

  task automatic check_status(input string name, input ddr_rx_pkg::ddr_rx_status_t got,
                              input ddr_rx_pkg::ddr_rx_status_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp));
  endtask

  // parity 1 is odd bits xor and parity 0 is even bits xor inverted
  function automatic logic [1:0] parity_model(input logic [15:0] d);
    logic odd_x;
    logic even_x;
    odd_x  = 1'b0;
    even_x = 1'b0;
    for (int i = 0; i < 16; i++)
    begin
      if (i % 2)
        odd_x = odd_x ^ d[i];
      else
        even_x = even_x ^ d[i];
    end
    return {odd_x, ~even_x};
  endfunction

  // one serial step of x^5+x^2+1
  function automatic logic [4:0] crc_step(input logic [4:0] c, input logic b);
    logic fb;
    fb = c[4] ^ b;
    return {c[3:0], 1'b0} ^ {2'b00, fb, 1'b0, fb};
  endfunction

  // output monitor sampling away from the active clock edge
  always @(negedge i_sys_clk)
  begin
    if (o_word_valid)
      got_words.push_back(o_word);
    if (o_status_valid)
    begin
      got_status         = o_status;
      busy_at_status     = o_busy;
      busy_before_status = busy_prev;
      status_seen        = 1'b1;
    end
    busy_prev = o_busy;
  end

  // target model that builds the frame bits, serves one bit per SCL change and checks results
  task automatic run_frame(input int n, input int bad_par, input logic [1:0] crc_pre,
                           input logic [3:0] token, input logic crc_flip);
    logic                       tx_bits [0:MAX_BITS-1];
    logic [4:0]                 crc;
    logic [1:0]                 par;
    logic                       pre_bit;
    logic                       last_scl;
    int                         nbits;
    int                         k;
    int                         wait_cnt;
    ddr_rx_pkg::ddr_rx_word_t   exp_word;
    ddr_rx_pkg::ddr_rx_status_t exp_status;
    nbits   = 0;
    crc     = 5'b11111;
    pre_bit = 1'b1;
    for (int w = 0; w < n; w++)
    begin
      // second preamble bit alternates per word and shows on o_pre
      pre_bit            = ((w % 2) == 0);
      tx_bits[nbits]     = 1'b1;
      tx_bits[nbits + 1] = pre_bit;
      nbits = nbits + 2;
      for (int b = 15; b >= 0; b--)
      begin
        tx_bits[nbits] = tx_data[w][b];
        crc   = crc_step(crc, tx_data[w][b]);
        nbits = nbits + 1;
      end
      par = parity_model(tx_data[w]);
      if (w == bad_par)
        par[0] = ~par[0];
      tx_bits[nbits]     = par[1];
      tx_bits[nbits + 1] = par[0];
      nbits = nbits + 2;
    end
    tx_bits[nbits]     = crc_pre[1];
    tx_bits[nbits + 1] = crc_pre[0];
    nbits = nbits + 2;
    for (int b = 3; b >= 0; b--)
    begin
      tx_bits[nbits] = token[b];
      nbits = nbits + 1;
    end
    crc[0] = crc[0] ^ crc_flip;
    for (int b = 4; b >= 0; b--)
    begin
      tx_bits[nbits] = crc[b];
      nbits = nbits + 1;
    end
    got_words.delete();
    status_seen = 1'b0;
    // first bit waits on SDA before SCL starts
    i_sda          = tx_bits[0];
    i_rx_cmd.words = ddr_rx_pkg::word_cnt_t'(n);
    i_rx_start     = 1'b1;
    @(negedge i_sys_clk);
    i_rx_start = 1'b0;
    last_scl   = o_scl;
    k          = 1;
    wait_cnt   = 0;
    while (k < nbits)
    begin
      @(negedge i_sys_clk);
      wait_cnt = wait_cnt + 1;
      if (o_scl !== last_scl)
      begin
        last_scl = o_scl;
        i_sda    = tx_bits[k];
        k        = k + 1;
        wait_cnt = 0;
      end
      else if (wait_cnt > 4 * HALF)
        fail_run("SCL stopped toggling in the middle of a frame");
    end
    wait_cnt = 0;
    while (!status_seen)
    begin
      @(negedge i_sys_clk);
      wait_cnt = wait_cnt + 1;
      if (wait_cnt > 4 * HALF)
        fail_run("no end-of-frame status after the last CRC bit");
    end
    i_sda = 1'b1;
    if (got_words.size() != n)
      fail_run($sformatf("received %0d words but the frame held %0d", got_words.size(), n));
    for (int w = 0; w < n; w++)
    begin
      exp_word = '{data: tx_data[w], parity_err: (w == bad_par)};
      check_word($sformatf("o_word[%0d]", w), got_words[w], exp_word);
    end
    exp_status = '{pre_err: (crc_pre != 2'b01), token_err: (token != 4'b1100),
                   crc_err: crc_flip, words: ddr_rx_pkg::word_cnt_t'(n)};
    check_status("o_status", got_status, exp_status);
    check_bit("o_busy at status", busy_at_status, 1'b0);
    check_bit("o_busy before status", busy_before_status, 1'b1);
    check_bit("o_pre", o_pre, pre_bit);
  endtask

  task automatic test_reset_state;
    check_bit("o_scl", o_scl, 1'b1);
    check_bit("o_busy", o_busy, 1'b0);
    check_bit("o_word_valid", o_word_valid, 1'b0);
    check_bit("o_status_valid", o_status_valid, 1'b0);
  endtask

  task automatic test_one_word;
    tx_data[0] = 16'hA53C;
    run_frame(1, -1, 2'b01, 4'b1100, 1'b0);
  endtask

  task automatic test_four_words;
    for (int w = 0; w < 4; w++)
      tx_data[w] = $random(seed);
    run_frame(4, -1, 2'b01, 4'b1100, 1'b0);
  endtask

  // word 2 counted from one is index 1
  task automatic test_parity_error;
    for (int w = 0; w < 4; w++)
      tx_data[w] = $random(seed);
    run_frame(4, 1, 2'b01, 4'b1100, 1'b0);
  endtask

  task automatic test_crc_word_errors;
    for (int f = 0; f < 4; f++)
    begin
      tx_data[0] = $random(seed);
      tx_data[1] = $random(seed);
      case (f)
        0: run_frame(2, -1, 2'b11, 4'b1100, 1'b0);
        1: run_frame(2, -1, 2'b01, 4'b1101, 1'b0);
        2: run_frame(2, -1, 2'b01, 4'b1100, 1'b1);
        default: run_frame(2, -1, 2'b01, 4'b1100, 1'b0);
      endcase
      repeat (2) @(negedge i_sys_clk);
    end
  endtask

  initial
  begin
    i_sys_rst      = 1'b0;
    i_rx_start     = 1'b0;
    i_rx_cmd       = '0;
    i_sda          = 1'b1;
    status_seen    = 1'b0;
    busy_prev      = 1'b0;
    repeat (4) @(negedge i_sys_clk);
    i_sys_rst = 1'b1;
    @(negedge i_sys_clk);
    test_reset_state();
    test_one_word();
    repeat (2) @(negedge i_sys_clk);
    test_four_words();
    repeat (2) @(negedge i_sys_clk);
    test_parity_error();
    repeat (2) @(negedge i_sys_clk);
    test_crc_word_errors();
    $display("RESULT: PASS");
    $finish;
  end

endmodule
